// ==== ext_harness_top.sv ====
// Harness top: external peripheral register bus and switch ack models
// for the CPU, peripheral, memory bank and external power domains
`timescale 1ns/100ps
`default_nettype none

module ext_harness_top
  import regbus_pkg::*;
  import power_pkg::*;
#(
  parameter int N_PERIPH           = 4,
  parameter int SWITCH_ACK_LATENCY = power_pkg::SWITCH_ACK_LATENCY
) (
  input  logic                               clk_i,
  input  logic                               reset_i,

  // Upstream register bus
  input  logic                               reg_valid_i,
  input  logic                               reg_write_i,
  input  logic [ADDR_W-1:0]                  reg_addr_i,
  input  logic [DATA_W-1:0]                  reg_wdata_i,
  input  logic [STRB_W-1:0]                  reg_wstrb_i,
  output logic [DATA_W-1:0]                  reg_rdata_o,
  output logic                               reg_error_o,
  output logic                               reg_ready_o,

  // Peripheral slots
  output logic [N_PERIPH-1:0]                slv_valid_o,
  output logic [N_PERIPH-1:0]                slv_write_o,
  output logic [N_PERIPH-1:0][OFFSET_W-1:0]  slv_offset_o,
  output logic [N_PERIPH-1:0][DATA_W-1:0]    slv_wdata_o,
  output logic [N_PERIPH-1:0][STRB_W-1:0]    slv_wstrb_o,
  input  logic [N_PERIPH-1:0][DATA_W-1:0]    slv_rdata_i,
  input  logic [N_PERIPH-1:0]                slv_error_i,
  input  logic [N_PERIPH-1:0]                slv_ready_i,

  // Power switches, active low
  input  logic                               cpu_switch_n_i,
  output logic                               cpu_switch_ack_n_o,
  input  logic                               periph_switch_n_i,
  output logic                               periph_switch_ack_n_o,
  input  logic [NUM_BANKS-1:0]               bank_switch_n_i,
  output logic [NUM_BANKS-1:0]               bank_switch_ack_n_o,
  input  logic [EXT_DOMAINS-1:0]             ext_switch_n_i,
  output logic [EXT_DOMAINS-1:0]             ext_switch_ack_n_o
);

  ext_periph_bus #(
    .N_PERIPH (N_PERIPH)
  ) periph_bus_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .reg_valid_i  (reg_valid_i),
    .reg_write_i  (reg_write_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_wstrb_i  (reg_wstrb_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_error_o  (reg_error_o),
    .reg_ready_o  (reg_ready_o),
    .slv_valid_o  (slv_valid_o),
    .slv_write_o  (slv_write_o),
    .slv_offset_o (slv_offset_o),
    .slv_wdata_o  (slv_wdata_o),
    .slv_wstrb_o  (slv_wstrb_o),
    .slv_rdata_i  (slv_rdata_i),
    .slv_error_i  (slv_error_i),
    .slv_ready_i  (slv_ready_i)
  );

  // One switch cell model per power domain group
  switch_ack_delay #(
    .WIDTH   (1),
    .LATENCY (SWITCH_ACK_LATENCY)
  ) cpu_ack_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .switch_n_i     (cpu_switch_n_i),
    .switch_ack_n_o (cpu_switch_ack_n_o)
  );

  switch_ack_delay #(
    .WIDTH   (1),
    .LATENCY (SWITCH_ACK_LATENCY)
  ) periph_ack_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .switch_n_i     (periph_switch_n_i),
    .switch_ack_n_o (periph_switch_ack_n_o)
  );

  switch_ack_delay #(
    .WIDTH   (NUM_BANKS),
    .LATENCY (SWITCH_ACK_LATENCY)
  ) bank_ack_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .switch_n_i     (bank_switch_n_i),
    .switch_ack_n_o (bank_switch_ack_n_o)
  );

  switch_ack_delay #(
    .WIDTH   (EXT_DOMAINS),
    .LATENCY (SWITCH_ACK_LATENCY)
  ) ext_ack_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .switch_n_i     (ext_switch_n_i),
    .switch_ack_n_o (ext_switch_ack_n_o)
  );

endmodule

`default_nettype wire

// ==== ext_periph_bus.sv ====
// External peripheral register bus demux
// Window decode, per-slot request fan-out, response select
`timescale 1ns/100ps
`default_nettype none

module ext_periph_bus
  import regbus_pkg::*;
#(
  // Must not exceed 2**SLOT_W
  parameter int N_PERIPH = 4
) (
  input  logic                               clk_i,
  input  logic                               reset_i,

  // Upstream request
  input  logic                               reg_valid_i,
  input  logic                               reg_write_i,
  input  reg_addr_u                          reg_addr_i,
  input  logic [DATA_W-1:0]                  reg_wdata_i,
  input  logic [STRB_W-1:0]                  reg_wstrb_i,

  // Upstream response
  output logic [DATA_W-1:0]                  reg_rdata_o,
  output logic                               reg_error_o,
  output logic                               reg_ready_o,

  // Slot requests
  output logic [N_PERIPH-1:0]                slv_valid_o,
  output logic [N_PERIPH-1:0]                slv_write_o,
  output logic [N_PERIPH-1:0][OFFSET_W-1:0]  slv_offset_o,
  output logic [N_PERIPH-1:0][DATA_W-1:0]    slv_wdata_o,
  output logic [N_PERIPH-1:0][STRB_W-1:0]    slv_wstrb_o,

  // Slot responses
  input  logic [N_PERIPH-1:0][DATA_W-1:0]    slv_rdata_i,
  input  logic [N_PERIPH-1:0]                slv_error_i,
  input  logic [N_PERIPH-1:0]                slv_ready_i
);

  logic                tag_match;
  logic [N_PERIPH-1:0] slot_sel;
  logic                req_hit;

  assign tag_match = (reg_addr_i.field.tag == EXT_PERIPH_TAG);

  // One-hot slot select that stays empty when the slot has no peripheral
  genvar i;
  for (i = 0; i < N_PERIPH; i++) begin : gen_slot
    assign slot_sel[i] = tag_match && (reg_addr_i.field.slot == SLOT_W'(i));

    // Write fields are broadcast and only valid is steered
    assign slv_write_o[i]  = reg_write_i;
    assign slv_offset_o[i] = reg_addr_i.field.offset;
    assign slv_wdata_o[i]  = reg_wdata_i;
    assign slv_wstrb_o[i]  = reg_wstrb_i;
  end

  assign req_hit     = |slot_sel;
  assign slv_valid_o = slot_sel & {N_PERIPH{reg_valid_i}};

  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    reg_ready_o = 1'b0;
    if (reg_valid_i) begin
      if (!req_hit) begin
        // Outside the window or unpopulated slot
        reg_error_o = 1'b1;
        reg_ready_o = 1'b1;
      end else begin
        for (int s = 0; s < N_PERIPH; s++) begin
          if (slot_sel[s]) begin
            reg_rdata_o = slv_rdata_i[s];
            reg_error_o = slv_error_i[s];
            reg_ready_o = slv_ready_i[s];
          end
        end
      end
    end
  end

  a_single_slot: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0(slv_valid_o)
  );

  a_idle_no_slot: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !reg_valid_i |-> (slv_valid_o == '0)
  );

  // Miss taken straight from the address fields
  a_miss_completes: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (reg_valid_i && ((reg_addr_i.field.tag != EXT_PERIPH_TAG) ||
                     (int'(reg_addr_i.field.slot) >= N_PERIPH)))
      |-> (reg_ready_o && reg_error_o && (reg_rdata_o == '0))
  );

endmodule

`default_nettype wire

// ==== flist.f ====
regbus_pkg.sv
power_pkg.sv
ext_periph_bus.sv
switch_ack_delay.sv
ext_harness_top.sv
tb_checker.sv
tb_top.sv

// ==== power_pkg.sv ====
// Power switch model constants
// Ack latency and the size of the bank and external domain groups
`default_nettype none

package power_pkg;

  // Cycles from switch request to switch ack
  parameter int SWITCH_ACK_LATENCY = 15;

  parameter int NUM_BANKS = 4;

  // Power domains outside the core system
  parameter int EXT_DOMAINS = 2;

endpackage

`default_nettype wire

// ==== regbus_pkg.sv ====
// Register bus field widths and the external peripheral window
// Address union with a raw view and a tag/slot/offset view
`default_nettype none

package regbus_pkg;

  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;
  parameter int STRB_W = DATA_W / 8;

  // Address split: window tag, slot index, register offset
  parameter int TAG_W    = 20;
  parameter int SLOT_W   = 2;
  parameter int OFFSET_W = 10;

  // Upper address bits of the external peripheral window
  parameter logic [TAG_W-1:0] EXT_PERIPH_TAG = 20'h3008_0;

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [SLOT_W-1:0]   slot;
    logic [OFFSET_W-1:0] offset;
  } reg_addr_fields_t;

  // Same 32 bits seen either as a plain address or as decoded fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    reg_addr_fields_t  field;
  } reg_addr_u;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and scan the log for failure

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_top -f flist.f \
  -Mdir obj_dir -o tb_top_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed with status $status"
  exit 1
fi

./obj_dir/tb_top_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$SIM_LOG"; then
  exit 1
fi

if ! grep -q "=== PASS ===" "$SIM_LOG"; then
  echo "Simulation ended without a verdict"
  exit 1
fi

exit 0

// ==== switch_ack_delay.sv ====
// Power switch cell model
// Fixed-latency shift chain from switch request to switch ack
`timescale 1ns/100ps
`default_nettype none

module switch_ack_delay #(
  parameter int WIDTH   = 1,
  parameter int LATENCY = 1
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic [WIDTH-1:0] switch_n_i,
  output logic [WIDTH-1:0] switch_ack_n_o
);

  logic [WIDTH-1:0] stage_q [LATENCY];

  // Stage 0 samples the request, last stage drives the ack
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < LATENCY; s++) begin
        stage_q[s] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int s = 1; s < LATENCY; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  assign switch_ack_n_o = stage_q[LATENCY-1];

  // Ack stays inactive until the first post-reset request has crossed the chain
  a_ack_idle_after_reset: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $fell(reset_i) |-> (switch_ack_n_o == '1) [*LATENCY]
  );

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
// Testbench checker: register bus window model, switch ack history,
// per-test counts and reporting
`timescale 1ns/100ps
`default_nettype none

module tb_checker
  import regbus_pkg::*;
  import power_pkg::*;
#(
  parameter int N_PERIPH = 4,
  parameter int LATENCY  = 15
) (
  input  logic                              clk_i,
  input  logic                              reset_i,
  input  logic [3:0]                        test_id_i,

  input  logic                              reg_valid_i,
  input  logic                              reg_write_i,
  input  logic [ADDR_W-1:0]                 reg_addr_i,
  input  logic [DATA_W-1:0]                 reg_wdata_i,
  input  logic [STRB_W-1:0]                 reg_wstrb_i,
  input  logic [DATA_W-1:0]                 reg_rdata_i,
  input  logic                              reg_error_i,
  input  logic                              reg_ready_i,

  input  logic [N_PERIPH-1:0]               slv_valid_i,
  input  logic [N_PERIPH-1:0]               slv_write_i,
  input  logic [N_PERIPH-1:0][OFFSET_W-1:0] slv_offset_i,
  input  logic [N_PERIPH-1:0][DATA_W-1:0]   slv_wdata_i,
  input  logic [N_PERIPH-1:0][STRB_W-1:0]   slv_wstrb_i,
  input  logic [N_PERIPH-1:0][DATA_W-1:0]   slv_rdata_i,
  input  logic [N_PERIPH-1:0]               slv_error_i,
  input  logic [N_PERIPH-1:0]               slv_ready_i,

  input  logic                              cpu_switch_n_i,
  input  logic                              cpu_switch_ack_n_i,
  input  logic                              periph_switch_n_i,
  input  logic                              periph_switch_ack_n_i,
  input  logic [NUM_BANKS-1:0]              bank_switch_n_i,
  input  logic [NUM_BANKS-1:0]              bank_switch_ack_n_i,
  input  logic [EXT_DOMAINS-1:0]            ext_switch_n_i,
  input  logic [EXT_DOMAINS-1:0]            ext_switch_ack_n_i,

  output int                                total_checks_o,
  output int                                total_errors_o
);

  localparam int SW_W = 2 + NUM_BANKS + EXT_DOMAINS;

  int              checks [8];
  int              errors [8];
  logic [SW_W-1:0] sw_hist [LATENCY];
  int              hist_ptr;
  int              stall_cycles;
  logic [3:0]      prev_test;

  initial begin
    for (int t = 0; t < 8; t++) begin
      checks[t] = 0;
      errors[t] = 0;
    end
    // Chain content before any request arrives is the inactive level
    for (int s = 0; s < LATENCY; s++) begin
      sw_hist[s] = {SW_W{1'b1}};
    end
    hist_ptr       = 0;
    stall_cycles   = 0;
    prev_test      = 4'd0;
    total_checks_o = 0;
    total_errors_o = 0;
  end

  function automatic string test_name(input int id);
    case (id)
      1: return "hit_routing";
      2: return "miss_response";
      3: return "idle_bus";
      4: return "back_pressure";
      5: return "switch_ack_delay";
      6: return "reset_state";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare(input int id, input string what,
                         input logic [63:0] exp_val, input logic [63:0] act_val);
    checks[id]++;
    total_checks_o++;
    if (act_val !== exp_val) begin
      errors[id]++;
      total_errors_o++;
      $display("[ERROR] %s %s: expected %0h actual %0h",
               test_name(id), what, exp_val, act_val);
    end
  endtask

  task automatic check_bus(input int id);
    reg_addr_u           a;
    int                  slot;
    logic                hit;
    logic [N_PERIPH-1:0] exp_valid;
    a.raw     = reg_addr_i;
    slot      = int'(a.field.slot);
    hit       = (a.field.tag == EXT_PERIPH_TAG) && (slot < N_PERIPH);
    exp_valid = '0;
    if (reg_valid_i && hit) begin
      exp_valid[slot] = 1'b1;
    end
    compare(id, "slot valid", exp_valid, slv_valid_i);
    if (!reg_valid_i) begin
      compare(id, "upstream ready", 1'b0, reg_ready_i);
    end else if (hit) begin
      compare(id, "slot write", reg_write_i, slv_write_i[slot]);
      compare(id, "slot offset", a.field.offset, slv_offset_i[slot]);
      compare(id, "slot wdata", reg_wdata_i, slv_wdata_i[slot]);
      compare(id, "slot wstrb", reg_wstrb_i, slv_wstrb_i[slot]);
      compare(id, "upstream rdata", slv_rdata_i[slot], reg_rdata_i);
      compare(id, "upstream error", slv_error_i[slot], reg_error_i);
      compare(id, "upstream ready", slv_ready_i[slot], reg_ready_i);
      if (id == 4 && !slv_ready_i[slot]) begin
        stall_cycles++;
      end
    end else begin
      compare(id, "upstream ready", 1'b1, reg_ready_i);
      compare(id, "upstream error", 1'b1, reg_error_i);
      compare(id, "upstream rdata", 32'h0, reg_rdata_i);
    end
  endtask

  // Ack now must equal the request seen LATENCY samples ago
  task automatic check_switch();
    logic [SW_W-1:0] req;
    logic [SW_W-1:0] ack;
    req = {cpu_switch_n_i, periph_switch_n_i, bank_switch_n_i, ext_switch_n_i};
    ack = {cpu_switch_ack_n_i, periph_switch_ack_n_i, bank_switch_ack_n_i,
           ext_switch_ack_n_i};
    if (reset_i) begin
      req = {SW_W{1'b1}};
    end
    compare(5, "switch ack", sw_hist[hist_ptr], ack);
    if (test_id_i == 4'd6) begin
      compare(6, "ack after reset", {SW_W{1'b1}}, ack);
    end
    sw_hist[hist_ptr] = req;
    hist_ptr = (hist_ptr + 1) % LATENCY;
  endtask

  task automatic report(input int id);
    if (id == 4 && stall_cycles == 0) begin
      errors[4]++;
      total_errors_o++;
      $display("Back-pressure test never saw a stalled slave");
    end
    $display("Test %0d %s: %0d checks, %0d errors",
             id, test_name(id), checks[id], errors[id]);
  endtask

  // Inputs change on the rising edge, so the falling edge sees settled values
  always @(negedge clk_i) begin
    if (test_id_i != prev_test) begin
      if (prev_test inside {4'd1, 4'd2, 4'd3, 4'd4, 4'd6}) begin
        report(prev_test);
      end
      if (test_id_i == 4'd7) begin
        report(5);
      end
      prev_test = test_id_i;
    end
    if (test_id_i != 4'd7) begin
      check_switch();
    end
    if (test_id_i >= 4'd1 && test_id_i <= 4'd4) begin
      check_bus(test_id_i);
    end
  end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
// Testbench top with clock, reset, random bus and switch stimulus,
// slave response models, DUT and checker instances
`timescale 1ns/100ps
`default_nettype none

module tb_top
  import regbus_pkg::*;
  import power_pkg::*;
();

  localparam int          N_PERIPH     = 4;
  localparam int          LATENCY      = SWITCH_ACK_LATENCY;
  localparam logic [31:0] SEED         = 32'hd587_fdfe;
  localparam int          RESET_CYCLES = 4;
  localparam int          N_HIT        = 200;
  localparam int          N_MISS       = 100;
  localparam int          N_IDLE       = 50;
  localparam int          N_BP         = 20;
  localparam int          BP_HOLD      = 4;
  localparam int          N_SWITCH     = 100;
  // Up to 16 cycles per hit transfer while slave ready is random
  localparam int          CYCLE_LIMIT  = RESET_CYCLES + LATENCY + N_HIT * 16 + N_MISS * 2
                                         + N_IDLE + N_BP * (BP_HOLD + 4) + N_SWITCH + 100;

  logic                              clk;
  logic                              reset;
  logic [3:0]                        test_id;
  logic                              reg_valid;
  logic                              reg_write;
  logic [ADDR_W-1:0]                 reg_addr;
  logic [DATA_W-1:0]                 reg_wdata;
  logic [STRB_W-1:0]                 reg_wstrb;
  logic [DATA_W-1:0]                 reg_rdata;
  logic                              reg_error;
  logic                              reg_ready;
  logic [N_PERIPH-1:0]               slv_valid;
  logic [N_PERIPH-1:0]               slv_write;
  logic [N_PERIPH-1:0][OFFSET_W-1:0] slv_offset;
  logic [N_PERIPH-1:0][DATA_W-1:0]   slv_wdata;
  logic [N_PERIPH-1:0][STRB_W-1:0]   slv_wstrb;
  logic [N_PERIPH-1:0][DATA_W-1:0]   slv_rdata;
  logic [N_PERIPH-1:0]               slv_error;
  logic [N_PERIPH-1:0]               slv_ready;
  logic                              cpu_sw;
  logic                              cpu_ack;
  logic                              periph_sw;
  logic                              periph_ack;
  logic [NUM_BANKS-1:0]              bank_sw;
  logic [NUM_BANKS-1:0]              bank_ack;
  logic [EXT_DOMAINS-1:0]            ext_sw;
  logic [EXT_DOMAINS-1:0]            ext_ack;
  logic                              bp_hold;
  logic                              bp_release;
  logic [31:0]                       stim_rng;
  logic [31:0]                       slave_rng;
  logic [31:0]                       sw_rng;
  int                                cycle_count;
  int                                total_checks;
  int                                total_errors;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  always #5 clk = ~clk;

  ext_harness_top #(
    .N_PERIPH           (N_PERIPH),
    .SWITCH_ACK_LATENCY (LATENCY)
  ) dut0 (
    .clk_i                 (clk),
    .reset_i               (reset),
    .reg_valid_i           (reg_valid),
    .reg_write_i           (reg_write),
    .reg_addr_i            (reg_addr),
    .reg_wdata_i           (reg_wdata),
    .reg_wstrb_i           (reg_wstrb),
    .reg_rdata_o           (reg_rdata),
    .reg_error_o           (reg_error),
    .reg_ready_o           (reg_ready),
    .slv_valid_o           (slv_valid),
    .slv_write_o           (slv_write),
    .slv_offset_o          (slv_offset),
    .slv_wdata_o           (slv_wdata),
    .slv_wstrb_o           (slv_wstrb),
    .slv_rdata_i           (slv_rdata),
    .slv_error_i           (slv_error),
    .slv_ready_i           (slv_ready),
    .cpu_switch_n_i        (cpu_sw),
    .cpu_switch_ack_n_o    (cpu_ack),
    .periph_switch_n_i     (periph_sw),
    .periph_switch_ack_n_o (periph_ack),
    .bank_switch_n_i       (bank_sw),
    .bank_switch_ack_n_o   (bank_ack),
    .ext_switch_n_i        (ext_sw),
    .ext_switch_ack_n_o    (ext_ack)
  );

  tb_checker #(
    .N_PERIPH (N_PERIPH),
    .LATENCY  (LATENCY)
  ) checker0 (
    .clk_i (clk), .reset_i (reset), .test_id_i (test_id),
    .reg_valid_i (reg_valid), .reg_write_i (reg_write), .reg_addr_i (reg_addr),
    .reg_wdata_i (reg_wdata), .reg_wstrb_i (reg_wstrb), .reg_rdata_i (reg_rdata),
    .reg_error_i (reg_error), .reg_ready_i (reg_ready),
    .slv_valid_i (slv_valid), .slv_write_i (slv_write), .slv_offset_i (slv_offset),
    .slv_wdata_i (slv_wdata), .slv_wstrb_i (slv_wstrb), .slv_rdata_i (slv_rdata),
    .slv_error_i (slv_error), .slv_ready_i (slv_ready),
    .cpu_switch_n_i (cpu_sw), .cpu_switch_ack_n_i (cpu_ack),
    .periph_switch_n_i (periph_sw), .periph_switch_ack_n_i (periph_ack),
    .bank_switch_n_i (bank_sw), .bank_switch_ack_n_i (bank_ack),
    .ext_switch_n_i (ext_sw), .ext_switch_ack_n_i (ext_ack),
    .total_checks_o (total_checks), .total_errors_o (total_errors)
  );

  // Slave models give a fresh random response for every slot each cycle
  always @(posedge clk) begin
    for (int s = 0; s < N_PERIPH; s++) begin
      slave_rng = xorshift32(slave_rng);
      slv_rdata[s] <= slave_rng;
      slave_rng = xorshift32(slave_rng);
      slv_error[s] <= slave_rng[3];
      if (bp_hold) begin
        slv_ready[s] <= 1'b0;
      end else if (bp_release) begin
        slv_ready[s] <= 1'b1;
      end else begin
        slv_ready[s] <= slave_rng[9];
      end
    end
  end

  // Switch requests change randomly on every edge even during reset
  always @(posedge clk) begin
    sw_rng = xorshift32(sw_rng);
    cpu_sw    <= sw_rng[0];
    periph_sw <= sw_rng[8];
    bank_sw   <= sw_rng[19:16];
    ext_sw    <= sw_rng[25:24];
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic make_hit_addr(output logic [ADDR_W-1:0] addr);
    reg_addr_u a;
    stim_rng = xorshift32(stim_rng);
    a.raw          = stim_rng;
    a.field.tag    = EXT_PERIPH_TAG;
    a.field.slot   = SLOT_W'(stim_rng[31:16] % N_PERIPH);
    addr = a.raw;
  endtask

  // Far tags, single-bit near misses and unpopulated slots
  task automatic make_miss_addr(output logic [ADDR_W-1:0] addr);
    reg_addr_u a;
    stim_rng = xorshift32(stim_rng);
    a.raw = stim_rng;
    if (N_PERIPH < (1 << SLOT_W) && stim_rng[31]) begin
      a.field.tag  = EXT_PERIPH_TAG;
      a.field.slot = SLOT_W'(N_PERIPH);
    end else if (stim_rng[30]) begin
      a.field.tag = EXT_PERIPH_TAG ^ (TAG_W'(1) << (stim_rng[15:11] % TAG_W));
    end else if (a.field.tag == EXT_PERIPH_TAG) begin
      a.field.tag[0] = ~a.field.tag[0];
    end
    addr = a.raw;
  endtask

  task automatic drive_request(input logic [ADDR_W-1:0] addr);
    stim_rng = xorshift32(stim_rng);
    reg_valid <= 1'b1;
    reg_write <= stim_rng[0];
    reg_wstrb <= stim_rng[7:4];
    reg_addr  <= addr;
    stim_rng = xorshift32(stim_rng);
    reg_wdata <= stim_rng;
  endtask

  // Half of the idle addresses fall inside the window
  task automatic drive_idle();
    reg_addr_u a;
    stim_rng = xorshift32(stim_rng);
    a.raw = stim_rng;
    if (stim_rng[31]) begin
      a.field.tag = EXT_PERIPH_TAG;
    end
    reg_valid <= 1'b0;
    reg_write <= stim_rng[2];
    reg_addr  <= a.raw;
    reg_wdata <= ~stim_rng;
    reg_wstrb <= stim_rng[11:8];
  endtask

  // Request is held until the edge that closes a ready cycle
  task automatic wait_ready();
    do begin
      @(posedge clk);
    end while (!reg_ready);
  endtask

  initial begin
    logic [ADDR_W-1:0] addr;
    clk = 1'b0;
    reset = 1'b1;
    test_id = 4'd0;
    reg_valid = 1'b0;
    reg_write = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    reg_wstrb = '0;
    slv_rdata = '0;
    slv_error = '0;
    slv_ready = '0;
    cpu_sw = 1'b1;
    periph_sw = 1'b1;
    bank_sw = '1;
    ext_sw = '1;
    bp_hold = 1'b0;
    bp_release = 1'b0;
    stim_rng = SEED;
    slave_rng = xorshift32(SEED);
    sw_rng = ~SEED;
    cycle_count = 0;

    repeat (RESET_CYCLES) @(posedge clk);
    reset   <= 1'b0;
    test_id <= 4'd6;
    repeat (LATENCY) @(posedge clk);

    test_id <= 4'd1;
    for (int n = 0; n < N_HIT; n++) begin
      make_hit_addr(addr);
      drive_request(addr);
      wait_ready();
    end

    test_id <= 4'd2;
    for (int n = 0; n < N_MISS; n++) begin
      make_miss_addr(addr);
      drive_request(addr);
      wait_ready();
    end

    test_id <= 4'd3;
    for (int n = 0; n < N_IDLE; n++) begin
      drive_idle();
      @(posedge clk);
    end

    // Slave ready is forced low for a while and then forced high
    test_id <= 4'd4;
    for (int n = 0; n < N_BP; n++) begin
      reg_valid  <= 1'b0;
      bp_hold    <= 1'b1;
      bp_release <= 1'b0;
      @(posedge clk);
      make_hit_addr(addr);
      drive_request(addr);
      repeat (BP_HOLD) @(posedge clk);
      bp_hold    <= 1'b0;
      bp_release <= 1'b1;
      wait_ready();
    end

    test_id    <= 4'd5;
    reg_valid  <= 1'b0;
    bp_release <= 1'b0;
    repeat (N_SWITCH) @(posedge clk);

    test_id <= 4'd7;
    repeat (2) @(posedge clk);
    $display("Total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
